// ==== src/ms7200_cfg_pkg.sv ====
`default_nettype none

package ms7200_cfg_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [5:0]  cmd_index_t;

    // one-hot phase encoding
    typedef enum logic [4:0] {
        PH_IDLE        = 5'b00001,
        PH_CONNECT     = 5'b00010,
        PH_INIT        = 5'b00100,
        PH_STATUS_READ = 5'b01000,
        PH_SETTING     = 5'b10000
    } cfg_phase_e;

    // ========================================
    // status word, 0x209C lands in byte 0
    // ========================================
    typedef union packed {
        logic [3:0][7:0] bytes;
        struct packed {
            logic [7:0]  rsvd_hi;
            logic [5:0]  rsvd_lo;
            logic [1:0]  lock_state;
            logic [15:0] freq_count;
        } fields;
    } status_word_u;

    // connect probe
    localparam reg_addr_t PROBE_ADDR  = 16'h0003;
    localparam reg_data_t PROBE_VALUE = 8'h5A;

    // status polling
    localparam reg_addr_t STATUS_BASE  = 16'h209C;
    localparam int        STATUS_BYTES = 4;

    // table layout, settings follow the init entries
    localparam int INIT_LEN    = 40;
    localparam int SETTING_LEN = 7;

    localparam logic [1:0] LOCK_IDLE   = 2'b00;
    localparam logic [1:0] LOCK_ACTIVE = 2'b10;

endpackage

`default_nettype wire

// ==== src/cfg_reg_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_reg_table import ms7200_cfg_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  cmd_index_t cmd_index,
    output reg_addr_t  table_addr,
    output reg_data_t  table_data
);

    logic [23:0] entry;

    // init entries 0..39, settings 40..46
    always_comb begin
        case (cmd_index)
            6'd0:    entry = {16'h0204, 8'h02};
            6'd1:    entry = {16'h0205, 8'h40};
            6'd2:    entry = {16'h0004, 8'h01};
            6'd3:    entry = {16'h0009, 8'h26};
            6'd4:    entry = {16'h102E, 8'h01};
            6'd5:    entry = {16'h1025, 8'hB0};
            6'd6:    entry = {16'h102D, 8'h83};
            6'd7:    entry = {16'h1000, 8'h20};
            6'd8:    entry = {16'h100F, 8'h04};
            6'd9:    entry = {16'h0003, 8'hC3};
            6'd10:   entry = {16'h103B, 8'h02};
            6'd11:   entry = {16'h00E1, 8'h00};
            6'd12:   entry = {16'h00A8, 8'h08};
            6'd13:   entry = {16'h000A, 8'h00};
            6'd14:   entry = {16'h0016, 8'h02};
            6'd15:   entry = {16'h00E2, 8'h01};
            6'd16:   entry = {16'h00C2, 8'h14};
            6'd17:   entry = {16'h102D, 8'hC7};
            6'd18:   entry = {16'h1005, 8'h04};
            6'd19:   entry = {16'h1003, 8'h14};
            6'd20:   entry = {16'h1004, 8'h01};
            6'd21:   entry = {16'h1000, 8'h60};
            6'd22:   entry = {16'h1020, 8'h13};
            6'd23:   entry = {16'h1021, 8'h04};
            6'd24:   entry = {16'h1022, 8'h04};
            6'd25:   entry = {16'h1023, 8'h0C};
            6'd26:   entry = {16'h102B, 8'h33};
            6'd27:   entry = {16'h102C, 8'h33};
            6'd28:   entry = {16'h00F0, 8'h10};
            6'd29:   entry = {16'h000C, 8'h80};
            6'd30:   entry = {16'h000C, 8'h00};
            6'd31:   entry = {16'h000A, 8'h04};
            6'd32:   entry = {16'h2000, 8'h0F};
            6'd33:   entry = {16'h2001, 8'h00};
            6'd34:   entry = {16'h2002, 8'h00};
            6'd35:   entry = {16'h2003, 8'h01};
            6'd36:   entry = {16'h209C, 8'h00};
            6'd37:   entry = {16'h209D, 8'h00};
            6'd38:   entry = {16'h209E, 8'h00};
            6'd39:   entry = {16'h209F, 8'h00};
            // lock settings
            6'd40:   entry = {16'h1010, 8'h01};
            6'd41:   entry = {16'h1024, 8'h00};
            6'd42:   entry = {16'h0200, 8'h00};
            6'd43:   entry = {16'h1024, 8'h70};
            6'd44:   entry = {16'h0200, 8'h07};
            6'd45:   entry = {16'h0215, 8'h01};
            6'd46:   entry = {16'h0215, 8'h00};
            default: entry = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            table_addr <= '0;
            table_data <= '0;
        end else begin
            table_addr <= entry[23:8];
            table_data <= entry[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== src/cfg_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_sequencer import ms7200_cfg_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  wire        busy,
    input  wire        byte_over,
    input  reg_data_t  data_out,
    input  reg_addr_t  table_addr,
    input  reg_data_t  table_data,
    input  wire        lock_event,
    output cmd_index_t cmd_index,
    output logic [1:0] status_step,
    output logic       poll_done,
    output logic       setting_start,
    output logic       iic_trig,
    output logic       w_r,
    output reg_addr_t  addr,
    output reg_data_t  data_in,
    output logic       init_over
);

    cfg_phase_e phase;
    cfg_phase_e phase_n;
    logic [5:0] step;
    logic [5:0] step_n;
    logic       busy_q;
    logic       busy_fall;
    logic       issue;
    logic       probe_ok;

    // transfer ends one cycle after busy drops
    assign busy_fall   = busy_q & ~busy;
    assign status_step = step[1:0];

    // ========================================
    // next phase and step
    // ========================================
    always_comb begin
        phase_n = phase;
        step_n  = step;
        issue   = 1'b0;
        case (phase)
            PH_IDLE: begin
                phase_n = PH_CONNECT;
                step_n  = '0;
                issue   = 1'b1;
            end
            PH_CONNECT: begin
                if (busy_fall) begin
                    issue = 1'b1;
                    if (step == '0) begin
                        step_n = 6'd1;
                    end else begin
                        // retry the probe write until read-back matches
                        step_n = '0;
                        if (probe_ok) begin
                            phase_n = PH_INIT;
                        end
                    end
                end
            end
            PH_INIT: begin
                if (busy_fall) begin
                    issue = 1'b1;
                    if (step == 6'(INIT_LEN - 1)) begin
                        phase_n = PH_STATUS_READ;
                        step_n  = '0;
                    end else begin
                        step_n = step + 6'd1;
                    end
                end
            end
            PH_STATUS_READ: begin
                if (busy_fall) begin
                    issue = 1'b1;
                    if (step == 6'(STATUS_BYTES - 1)) begin
                        step_n = '0;
                        if (lock_event) begin
                            phase_n = PH_SETTING;
                        end
                    end else begin
                        step_n = step + 6'd1;
                    end
                end
            end
            PH_SETTING: begin
                if (busy_fall) begin
                    issue = 1'b1;
                    if (step == 6'(SETTING_LEN - 1)) begin
                        phase_n = PH_STATUS_READ;
                        step_n  = '0;
                    end else begin
                        step_n = step + 6'd1;
                    end
                end
            end
            default: begin
                phase_n = PH_IDLE;
                step_n  = '0;
            end
        endcase
    end

    // ========================================
    // control registers
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase         <= PH_IDLE;
            step          <= '0;
            busy_q        <= 1'b0;
            probe_ok      <= 1'b0;
            cmd_index     <= '0;
            iic_trig      <= 1'b0;
            w_r           <= 1'b1;
            poll_done     <= 1'b0;
            setting_start <= 1'b0;
            init_over     <= 1'b0;
        end else begin
            phase         <= phase_n;
            step          <= step_n;
            busy_q        <= busy;
            iic_trig      <= issue;
            poll_done     <= (phase == PH_STATUS_READ) && busy_fall &&
                             (step == 6'(STATUS_BYTES - 1));
            setting_start <= (phase_n == PH_SETTING) && (phase != PH_SETTING);

            if (phase == PH_CONNECT && step == 6'd1 && byte_over) begin
                probe_ok <= (data_out == PROBE_VALUE);
            end

            if (issue) begin
                case (phase_n)
                    PH_CONNECT:     w_r <= (step_n == '0);
                    PH_STATUS_READ: w_r <= 1'b0;
                    default:        w_r <= 1'b1;
                endcase
            end

            // table entry is fetched one transfer ahead
            if (phase == PH_SETTING && phase_n == PH_STATUS_READ) begin
                cmd_index <= cmd_index_t'(INIT_LEN);
                init_over <= 1'b1;
            end else if (issue && (phase_n == PH_INIT || phase_n == PH_SETTING)) begin
                cmd_index <= cmd_index + 6'd1;
            end
        end
    end

    // transfer payload
    always_ff @(posedge clk) begin
        if (issue) begin
            case (phase_n)
                PH_CONNECT: begin
                    addr    <= PROBE_ADDR;
                    data_in <= PROBE_VALUE;
                end
                PH_STATUS_READ: begin
                    addr    <= STATUS_BASE + reg_addr_t'(step_n);
                    data_in <= '0;
                end
                default: begin
                    addr    <= table_addr;
                    data_in <= table_data;
                end
            endcase
        end
    end

    // engine must be idle whenever a transfer starts
    a_trig_not_busy: assert property (@(posedge clk) disable iff (!rstn)
        iic_trig |-> !busy)
        else $error("iic_trig issued while engine busy");

endmodule

`default_nettype wire

// ==== src/lock_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module lock_detect import ms7200_cfg_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  wire        byte_over,
    input  reg_data_t  data_out,
    input  wire  [1:0] status_step,
    input  wire        poll_done,
    input  wire        setting_start,
    output logic       lock_event
);

    status_word_u work;
    logic [1:0]   prev_lock;
    logic         prev_valid;

    // assemble the word one read at a time
    always_ff @(posedge clk) begin
        if (byte_over) begin
            work.bytes[status_step] <= data_out;
        end
    end

    // ========================================
    // compare against the previous poll
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            prev_lock  <= LOCK_IDLE;
            prev_valid <= 1'b0;
            lock_event <= 1'b0;
        end else begin
            if (poll_done) begin
                prev_lock  <= work.fields.lock_state;
                prev_valid <= 1'b1;
            end
            // held until the settings sequence starts
            if (setting_start) begin
                lock_event <= 1'b0;
            end else if (poll_done && prev_valid && prev_lock == LOCK_IDLE &&
                         work.fields.lock_state == LOCK_ACTIVE) begin
                lock_event <= 1'b1;
            end
        end
    end

    // last byte must be in before the poll is judged
    a_no_byte_at_poll_done: assert property (@(posedge clk) disable iff (!rstn)
        poll_done |-> !byte_over)
        else $error("byte_over during poll_done");

endmodule

`default_nettype wire

// ==== src/ms7200_cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ms7200_cfg_top import ms7200_cfg_pkg::*; (
    input  wire       clk,
    input  wire       rstn,
    output logic      init_over,
    output logic      iic_trig,
    output logic      w_r,
    output reg_addr_t addr,
    output reg_data_t data_in,
    input  wire       busy,
    input  wire       byte_over,
    input  reg_data_t data_out
);

    cmd_index_t cmd_index;
    reg_addr_t  table_addr;
    reg_data_t  table_data;
    logic [1:0] status_step;
    logic       poll_done;
    logic       setting_start;
    logic       lock_event;

    cfg_sequencer i_sequencer (
        .clk           (clk),
        .rstn          (rstn),
        .busy          (busy),
        .byte_over     (byte_over),
        .data_out      (data_out),
        .table_addr    (table_addr),
        .table_data    (table_data),
        .lock_event    (lock_event),
        .cmd_index     (cmd_index),
        .status_step   (status_step),
        .poll_done     (poll_done),
        .setting_start (setting_start),
        .iic_trig      (iic_trig),
        .w_r           (w_r),
        .addr          (addr),
        .data_in       (data_in),
        .init_over     (init_over)
    );

    cfg_reg_table i_reg_table (
        .clk        (clk),
        .rstn       (rstn),
        .cmd_index  (cmd_index),
        .table_addr (table_addr),
        .table_data (table_data)
    );

    lock_detect i_lock_detect (
        .clk           (clk),
        .rstn          (rstn),
        .byte_over     (byte_over),
        .data_out      (data_out),
        .status_step   (status_step),
        .poll_done     (poll_done),
        .setting_start (setting_start),
        .lock_event    (lock_event)
    );

endmodule

`default_nettype wire

// ==== verif/iic_engine_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module iic_engine_model (
    input  wire        clk,
    input  wire        iic_trig,
    input  wire        w_r,
    input  wire [15:0] addr,
    input  wire [7:0]  data_in,
    output logic       busy,
    output logic       byte_over,
    output logic [7:0] data_out
);

    localparam int LOG_DEPTH = 2048;

    integer      seed;
    int          remain;
    int          byte_sel;
    logic        pending;
    logic        req_write;
    logic [15:0] req_addr;
    logic [31:0] last_word;
    logic [7:0]  probe_q [$];
    logic [31:0] status_q [$];

    // one entry per accepted trigger
    logic [15:0] log_addr [0:LOG_DEPTH-1];
    logic [7:0]  log_data [0:LOG_DEPTH-1];
    logic        log_write [0:LOG_DEPTH-1];
    int          log_count;
    int          trig_while_busy;

    task automatic push_probe_reply(input logic [7:0] value);
        probe_q.push_back(value);
    endtask

    task automatic push_status_word(input logic [31:0] word);
        status_q.push_back(word);
    endtask

    initial begin
        seed            = 32'h3830_07d5;
        busy            = 1'b0;
        byte_over       = 1'b0;
        data_out        = 8'h00;
        pending         = 1'b0;
        req_write       = 1'b1;
        req_addr        = 16'h0000;
        remain          = 0;
        last_word       = 32'h0;
        log_count       = 0;
        trig_while_busy = 0;
        forever begin
            @(negedge clk);
            if (iic_trig && busy) begin
                trig_while_busy++;
            end
            byte_over = 1'b0;
            if (pending) begin
                // busy rises the cycle after the trigger
                pending = 1'b0;
                busy    = 1'b1;
                remain  = 3 + ($unsigned($random(seed)) % 18);
            end else if (busy) begin
                remain = remain - 1;
                if (remain == 0) begin
                    busy = 1'b0;
                end else if (remain == 1 && !req_write) begin
                    byte_over = 1'b1;
                    if (req_addr == 16'h0003) begin
                        if (probe_q.size() > 0) begin
                            data_out = probe_q.pop_front();
                        end else begin
                            data_out = 8'h5A;
                        end
                    end else begin
                        // new poll word taken at the first status register
                        if (req_addr == 16'h209C && status_q.size() > 0) begin
                            last_word = status_q.pop_front();
                        end
                        byte_sel = req_addr - 16'h209C;
                        data_out = last_word[8 * byte_sel +: 8];
                    end
                end
            end else if (iic_trig) begin
                req_write = w_r;
                req_addr  = addr;
                if (log_count < LOG_DEPTH) begin
                    log_addr[log_count]  = addr;
                    log_data[log_count]  = data_in;
                    log_write[log_count] = w_r;
                    log_count++;
                end
                pending = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_ms7200_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ms7200_cfg;

    // 400 transfers of up to 25 cycles at 4 ns
    localparam int WATCHDOG_NS = 400 * 25 * 4;

    // kept reference init entries, {addr, data}
    localparam logic [23:0] INIT_EXP [0:39] = '{
        24'h0204_02, 24'h0205_40, 24'h0004_01, 24'h0009_26, 24'h102E_01, 24'h1025_B0,
        24'h102D_83, 24'h1000_20, 24'h100F_04, 24'h0003_C3, 24'h103B_02, 24'h00E1_00,
        24'h00A8_08, 24'h000A_00, 24'h0016_02, 24'h00E2_01, 24'h00C2_14, 24'h102D_C7,
        24'h1005_04, 24'h1003_14, 24'h1004_01, 24'h1000_60, 24'h1020_13, 24'h1021_04,
        24'h1022_04, 24'h1023_0C, 24'h102B_33, 24'h102C_33, 24'h00F0_10, 24'h000C_80,
        24'h000C_00, 24'h000A_04, 24'h2000_0F, 24'h2001_00, 24'h2002_00, 24'h2003_01,
        24'h209C_00, 24'h209D_00, 24'h209E_00, 24'h209F_00
    };

    localparam logic [23:0] SETTING_EXP [0:6] = '{
        24'h1010_01, 24'h1024_00, 24'h0200_00, 24'h1024_70, 24'h0200_07, 24'h0215_01,
        24'h0215_00
    };

    logic        clk = 1'b0;
    logic        rstn;
    logic        init_over;
    logic        iic_trig;
    logic        w_r;
    logic [15:0] addr;
    logic [7:0]  data_in;
    logic        busy;
    logic        byte_over;
    logic [7:0]  data_out;
    int          errors;
    int          checks;
    string       test_name;

    always #2 clk = ~clk;

    ms7200_cfg_top i_dut (
        .clk       (clk),
        .rstn      (rstn),
        .init_over (init_over),
        .iic_trig  (iic_trig),
        .w_r       (w_r),
        .addr      (addr),
        .data_in   (data_in),
        .busy      (busy),
        .byte_over (byte_over),
        .data_out  (data_out)
    );

    iic_engine_model i_engine (
        .clk       (clk),
        .iic_trig  (iic_trig),
        .w_r       (w_r),
        .addr      (addr),
        .data_in   (data_in),
        .busy      (busy),
        .byte_over (byte_over),
        .data_out  (data_out)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s, %s: expected 0x%0h, actual 0x%0h",
                     test_name, name, expected, actual);
        end
    endtask

    task automatic wait_transfers(input int count);
        while (i_engine.log_count < count) begin
            @(negedge clk);
        end
    endtask

    task automatic check_entry(input string name, input int idx, input logic write,
                               input logic [15:0] exp_addr, input logic [7:0] exp_data);
        check_value({name, " w_r"}, 32'(write), 32'(i_engine.log_write[idx]));
        check_value({name, " addr"}, 32'(exp_addr), 32'(i_engine.log_addr[idx]));
        if (write) begin
            check_value({name, " data"}, 32'(exp_data), 32'(i_engine.log_data[idx]));
        end
    endtask

    // four reads, 0x209C upwards
    task automatic check_poll(input string name, input int first);
        int b;
        for (b = 0; b < 4; b++) begin
            check_entry($sformatf("%s byte %0d", name, b), first + b, 1'b0,
                        16'h209C + 16'(b), 8'h00);
        end
    endtask

    // lock_state sits in bits 17:16 of the word
    function automatic logic [31:0] status_word(input logic [1:0] lock,
                                                input logic [15:0] freq);
        return {8'h00, 6'b000000, lock, freq};
    endfunction

    // ========================================
    // directed tests
    // ========================================
    task automatic reset_sequence();
        int wait_cycles;
        test_name = "reset";
        rstn = 1'b0;
        repeat (10) begin
            @(negedge clk);
        end
        check_value("reset iic_trig", 0, 32'(iic_trig));
        check_value("reset init_over", 0, 32'(init_over));
        check_value("reset w_r", 1, 32'(w_r));
        rstn = 1'b1;
        wait_cycles = 0;
        while (!iic_trig && wait_cycles < 3) begin
            @(negedge clk);
            wait_cycles++;
        end
        check_value("first trigger", 1, 32'(iic_trig));
        check_value("first trigger w_r", 1, 32'(w_r));
        check_value("after reset init_over", 0, 32'(init_over));
    endtask

    task automatic connect_retry();
        test_name = "connect retry";
        i_engine.push_probe_reply(8'h00);
        i_engine.push_probe_reply(8'h5A);
        wait_transfers(5);
        check_entry("probe write 1", 0, 1'b1, 16'h0003, 8'h5A);
        check_entry("probe read 1", 1, 1'b0, 16'h0003, 8'h00);
        check_entry("probe write 2", 2, 1'b1, 16'h0003, 8'h5A);
        check_entry("probe read 2", 3, 1'b0, 16'h0003, 8'h00);
        check_entry("first init write", 4, 1'b1, 16'h0204, 8'h02);
    endtask

    task automatic init_table_writes();
        int k;
        test_name = "init table";
        wait_transfers(44);
        for (k = 0; k < 40; k++) begin
            check_entry($sformatf("init write %0d", k), 4 + k, 1'b1,
                        INIT_EXP[k][23:8], INIT_EXP[k][7:0]);
        end
    endtask

    task automatic status_polling();
        int p;
        test_name = "status polling";
        // locked twice, then dropped twice
        i_engine.push_status_word(status_word(2'b10, 16'h1200));
        i_engine.push_status_word(status_word(2'b10, 16'h1201));
        i_engine.push_status_word(status_word(2'b00, 16'h0000));
        i_engine.push_status_word(status_word(2'b00, 16'h0000));
        wait_transfers(60);
        for (p = 0; p < 4; p++) begin
            check_poll($sformatf("poll %0d", p + 1), 44 + 4 * p);
        end
        check_value("init_over while polling", 0, 32'(init_over));
    endtask

    task automatic lock_settings();
        int k;
        test_name = "lock settings";
        // 00 then 10 arms the event, taken when the following poll ends
        i_engine.push_status_word(status_word(2'b10, 16'h1202));
        i_engine.push_status_word(status_word(2'b10, 16'h1203));
        wait_transfers(75);
        check_value("init_over at last setting", 0, 32'(init_over));
        wait_transfers(79);
        check_poll("poll 5", 60);
        check_poll("poll 6", 64);
        for (k = 0; k < 7; k++) begin
            check_entry($sformatf("setting write %0d", k), 68 + k, 1'b1,
                        SETTING_EXP[k][23:8], SETTING_EXP[k][7:0]);
        end
        check_poll("resumed poll", 75);
        check_value("init_over after settings", 1, 32'(init_over));
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        rstn      = 1'b0;
        test_name = "";
        reset_sequence();
        connect_retry();
        init_table_writes();
        status_polling();
        lock_settings();
        test_name = "back-pressure";
        check_value("iic_trig while busy", 0, 32'(i_engine.trig_while_busy));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the controller stopped before all transfers were seen");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/ms7200_cfg_pkg.sv
src/cfg_reg_table.sv
src/cfg_sequencer.sv
src/lock_detect.sv
src/ms7200_cfg_top.sv
verif/iic_engine_model.sv
verif/tb_ms7200_cfg.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator and run, pass only if the pass line is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_ms7200_cfg -o sim_ms7200_cfg || { echo "build failed"; exit 1; }

./obj_dir/sim_ms7200_cfg | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
